/* list.f */
hdl/mem_pkg.sv
hdl/fetch_queue.sv
hdl/lsb_buffer.sv
hdl/byte_engine.sv
hdl/load_extend.sv
hdl/mem_unit.sv
tests/mem_unit_properties.sv
tests/tb_mem_unit.sv

/* tests/tb_mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_unit
    import mem_pkg::*;
();

    logic             clk = 1'b0;
    logic             rst = 1'b0;
    logic             fetch_valid;
    logic [xlen-1:0]  fetch_addr;
    logic             issue_valid;
    logic [tag_w-1:0] issue_tag;
    logic [op_w-1:0]  issue_op;
    logic [xlen-1:0]  issue_addr;
    logic [xlen-1:0]  issue_data;
    logic             commit_valid;
    logic [tag_w-1:0] commit_tag;
    logic [7:0]       ram_rdata = 8'h00;
    logic [xlen-1:0]  ram_addr;
    logic [7:0]       ram_wdata;
    logic             ram_we;
    logic             ins_ready;
    logic [xlen-1:0]  ins_value;
    logic             mem_done;
    logic [tag_w-1:0] done_tag;
    logic [xlen-1:0]  done_value;
    logic             done_is_load;
    logic             fetch_full;

    logic [7:0]      ram [256];
    logic [7:0]      model_mem [256];
    logic [31:0]     seed = 32'h7fa28719;
    logic [xlen-1:0] exp_ins [$];
    logic [op_w-1:0] load_ops [5] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu};
    logic [op_w-1:0] store_ops [3] = '{op_sb, op_sh, op_sw};
    int              ins_cnt = 0;
    int              fetch_total = 0;
    int              errors = 0;
    int              test_err0 = 0;
    int              tests_run = 0;
    int              tests_failed = 0;

    mem_unit dut0 (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
        .issue_valid(issue_valid), .issue_tag(issue_tag), .issue_op(issue_op),
        .issue_addr(issue_addr), .issue_data(issue_data),
        .commit_valid(commit_valid), .commit_tag(commit_tag),
        .ram_rdata(ram_rdata), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .ins_ready(ins_ready), .ins_value(ins_value),
        .mem_done(mem_done), .done_tag(done_tag), .done_value(done_value),
        .done_is_load(done_is_load), .fetch_full(fetch_full)
    );

    always #10 clk = ~clk;

    // Synchronous byte RAM with one cycle read latency
    always @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr[7:0]] <= ram_wdata;
        end
        ram_rdata <= ram[ram_addr[7:0]];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected load result from the model memory
    function automatic logic [xlen-1:0] load_value(input logic [op_w-1:0] op,
                                                   input logic [xlen-1:0] addr);
        logic [31:0] w;
        w = {model_mem[8'(addr + 32'd3)], model_mem[8'(addr + 32'd2)],
             model_mem[8'(addr + 32'd1)], model_mem[addr[7:0]]};
        case (op)
            op_lb:   return {{24{w[7]}}, w[7:0]};
            op_lh:   return {{16{w[15]}}, w[15:0]};
            op_lbu:  return {24'h000000, w[7:0]};
            op_lhu:  return {16'h0000, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic store_model(input logic [op_w-1:0] op, input logic [xlen-1:0] addr,
                               input logic [xlen-1:0] data);
        int n;
        n = (op == op_sb) ? 1 : (op == op_sh) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model_mem[8'(addr + 32'(i))] = data[8*i +: 8];
        end
    endtask

    // Fetch results come back in push order
    always @(posedge clk) begin
        if (rst && ins_ready) begin
            if (exp_ins.size() == 0) begin
                $display("Instruction result arrived with no fetch pending");
                errors = errors + 1;
            end else begin
                check_value("ins_value", ins_value, exp_ins.pop_front());
            end
            ins_cnt <= ins_cnt + 1;
        end
    end

    // Single-cycle push followed by an idle cycle so fetch_full is current
    task automatic push_fetch(input logic [xlen-1:0] addr);
        int n;
        n = 0;
        @(posedge clk);
        while (fetch_full && n < 200) begin
            @(posedge clk);
            n = n + 1;
        end
        if (fetch_full) begin
            $display("Fetch queue stayed full too long");
            errors = errors + 1;
        end else begin
            fetch_valid <= 1'b1;
            fetch_addr  <= addr;
            exp_ins.push_back(load_value(op_lw, addr));
            fetch_total = fetch_total + 1;
            @(posedge clk);
            fetch_valid <= 1'b0;
        end
    endtask

    task automatic wait_fetches();
        int n;
        n = 0;
        while (ins_cnt != fetch_total && n < 500) begin
            @(posedge clk);
            n = n + 1;
        end
        if (ins_cnt != fetch_total) begin
            $display("Timeout waiting for instruction results");
            errors = errors + 1;
        end
    endtask

    task automatic issue_and_commit(input logic [tag_w-1:0] tag, input logic [op_w-1:0] op,
                                    input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_tag   <= tag;
        issue_op    <= op;
        issue_addr  <= addr;
        issue_data  <= data;
        @(posedge clk);
        issue_valid  <= 1'b0;
        commit_valid <= 1'b1;
        commit_tag   <= tag;
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic wait_mem_done(output logic seen, output int ins_seen);
        int n;
        n = 0;
        seen = 1'b0;
        ins_seen = 0;
        while (!seen && n < 100) begin
            @(posedge clk);
            if (ins_ready) begin
                ins_seen = ins_seen + 1;
            end
            if (mem_done) begin
                seen = 1'b1;
            end
            n = n + 1;
        end
    endtask

    task automatic run_mem_op(input logic [tag_w-1:0] tag, input logic [op_w-1:0] op,
                              input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                              output int ins_seen);
        logic            seen;
        logic            is_store;
        logic [xlen-1:0] exp_value;
        is_store  = (op == op_sb) || (op == op_sh) || (op == op_sw);
        exp_value = is_store ? '0 : load_value(op, addr);
        issue_and_commit(tag, op, addr, data);
        wait_mem_done(seen, ins_seen);
        if (!seen) begin
            $display("Timeout waiting for mem_done of tag %0d", tag);
            errors = errors + 1;
        end else begin
            check_value("done_tag", 32'(done_tag), 32'(tag));
            check_value("done_value", done_value, exp_value);
            check_value("done_is_load", 32'(done_is_load), 32'(!is_store));
        end
        if (is_store) begin
            store_model(op, addr, data);
        end
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (errors == test_err0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("%s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        logic [xlen-1:0] addr;
        logic [op_w-1:0] op;
        logic [tag_w-1:0] tag;
        int ins_seen;
        int n;
        fetch_valid  <= 1'b0;
        fetch_addr   <= '0;
        issue_valid  <= 1'b0;
        issue_tag    <= '0;
        issue_op     <= '0;
        issue_addr   <= '0;
        issue_data   <= '0;
        commit_valid <= 1'b0;
        commit_tag   <= '0;
        for (int i = 0; i < 256; i++) begin
            ram[i]       = 8'(i * 29 + 7);
            model_mem[i] = 8'(i * 29 + 7);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_value("ram_we", 32'(ram_we), 32'h0);
        check_value("ins_ready", 32'(ins_ready), 32'h0);
        check_value("mem_done", 32'(mem_done), 32'h0);
        check_value("fetch_full", 32'(fetch_full), 32'h0);
        end_test("reset state");

        for (int i = 0; i < 12; i++) begin
            seed = xorshift(seed);
            push_fetch(seed);
        end
        wait_fetches();
        end_test("fetch queue");

        for (int i = 0; i < 16; i++) begin
            seed = xorshift(seed);
            op = load_ops[seed % 5];
            tag = seed[10:8];
            seed = xorshift(seed);
            run_mem_op(tag, op, seed, 32'h0, ins_seen);
        end
        end_test("loads");

        for (int i = 0; i < 12; i++) begin
            seed = xorshift(seed);
            op = store_ops[seed % 3];
            tag = seed[10:8];
            seed = xorshift(seed);
            addr = seed;
            seed = xorshift(seed);
            run_mem_op(tag, op, addr, seed, ins_seen);
            run_mem_op(tag + 3'd1, op_lw, addr, 32'h0, ins_seen);
        end
        end_test("stores");

        for (int i = 0; i < 6; i++) begin
            seed = xorshift(seed);
            push_fetch(seed);
        end
        seed = xorshift(seed);
        run_mem_op(3'd2, op_lh, seed, 32'h0, ins_seen);
        // Only fetches already running when the commit lands may finish first
        if (ins_seen > 2) begin
            $display("Fetch results overtook a committed load");
            errors = errors + 1;
        end
        if (ins_cnt >= fetch_total) begin
            $display("No fetch was left queued behind the committed load");
            errors = errors + 1;
        end
        wait_fetches();
        end_test("priority");

        @(posedge clk);
        commit_valid <= 1'b1;
        commit_tag   <= 3'd5;
        @(posedge clk);
        commit_valid <= 1'b0;
        n = 0;
        while (n < 40) begin
            @(posedge clk);
            if (mem_done) begin
                $display("mem_done after a commit of an idle tag");
                errors = errors + 1;
            end
            n = n + 1;
        end
        seed = xorshift(seed);
        run_mem_op(3'd5, op_lbu, seed, 32'h0, ins_seen);
        end_test("ignored commit");

        if (dut0.props0.fail_count != 0) begin
            $display("Assertions failed %0d times during the run", dut0.props0.fail_count);
            errors = errors + dut0.props0.fail_count;
        end

        $display("Tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/mem_unit_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_unit_properties
    import mem_pkg::*;
(
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            ram_we,
    input wire logic            ins_ready,
    input wire logic            mem_done,
    input wire logic            fetch_valid,
    input wire logic            fetch_full,
    input wire logic            fq_pop,
    input wire logic            cm_take,
    input wire logic [op_w-1:0] cm_op,
    input wire logic            eng_done
);

    logic read_run;
    logic read_start;
    int   fail_count = 0;

    assign read_start = fq_pop ||
                        (cm_take && (cm_op != op_sb) && (cm_op != op_sh) && (cm_op != op_sw));

    // A read runs from its accept cycle until the engine reports done
    always_ff @(posedge clk) begin
        if (!rst) begin
            read_run <= 1'b0;
        end else if (read_start) begin
            read_run <= 1'b1;
        end else if (eng_done) begin
            read_run <= 1'b0;
        end
    end

    a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst)
        ram_we |-> !read_run)
        else begin
            $error("RAM write while a read is running");
            fail_count = fail_count + 1;
        end

    a_results_apart: assert property (@(posedge clk) disable iff (!rst)
        !(ins_ready && mem_done))
        else begin
            $error("ins_ready and mem_done high in the same cycle");
            fail_count = fail_count + 1;
        end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        fetch_valid |-> !fetch_full)
        else begin
            $error("Fetch pushed while the fetch queue is full");
            fail_count = fail_count + 1;
        end

endmodule

bind mem_unit mem_unit_properties props0 (
    .clk(clk), .rst(rst), .ram_we(ram_we),
    .ins_ready(ins_ready), .mem_done(mem_done),
    .fetch_valid(fetch_valid), .fetch_full(fetch_full),
    .fq_pop(fq_pop), .cm_take(cm_take), .cm_op(cm_op), .eng_done(eng_done)
);

`default_nettype wire

/* hdl/mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_unit
    import mem_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             fetch_valid,
    input  wire logic [xlen-1:0]  fetch_addr,
    input  wire logic             issue_valid,
    input  wire logic [tag_w-1:0] issue_tag,
    input  wire logic [op_w-1:0]  issue_op,
    input  wire logic [xlen-1:0]  issue_addr,
    input  wire logic [xlen-1:0]  issue_data,
    input  wire logic             commit_valid,
    input  wire logic [tag_w-1:0] commit_tag,
    input  wire logic [7:0]       ram_rdata,
    output logic      [xlen-1:0]  ram_addr,
    output logic      [7:0]       ram_wdata,
    output logic                  ram_we,
    output logic                  ins_ready,
    output logic      [xlen-1:0]  ins_value,
    output logic                  mem_done,
    output logic      [tag_w-1:0] done_tag,
    output logic      [xlen-1:0]  done_value,
    output logic                  done_is_load,
    output logic                  fetch_full
);

    logic             fq_valid;
    logic [xlen-1:0]  fq_addr;
    logic             fq_pop;
    logic             cm_valid;
    logic [op_w-1:0]  cm_op;
    logic [xlen-1:0]  cm_addr;
    logic [xlen-1:0]  cm_data;
    logic [tag_w-1:0] cm_tag;
    logic             cm_take;
    logic             eng_done;
    logic             eng_is_ins;
    logic [op_w-1:0]  eng_op;
    logic [tag_w-1:0] eng_tag;
    logic [xlen-1:0]  eng_word;

    fetch_queue fq0 (
        .clk(clk), .rst(rst),
        .push(fetch_valid), .push_addr(fetch_addr),
        .pop(fq_pop), .head_valid(fq_valid), .head_addr(fq_addr),
        .full(fetch_full)
    );

    lsb_buffer lsb0 (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_tag(issue_tag), .issue_op(issue_op),
        .issue_addr(issue_addr), .issue_data(issue_data),
        .commit_valid(commit_valid), .commit_tag(commit_tag), .take(cm_take),
        .cm_valid(cm_valid), .cm_op(cm_op), .cm_addr(cm_addr),
        .cm_data(cm_data), .cm_tag(cm_tag)
    );

    byte_engine eng0 (
        .clk(clk), .rst(rst),
        .fq_valid(fq_valid), .fq_addr(fq_addr), .fq_pop(fq_pop),
        .cm_valid(cm_valid), .cm_op(cm_op), .cm_addr(cm_addr),
        .cm_data(cm_data), .cm_tag(cm_tag), .cm_take(cm_take),
        .ram_rdata(ram_rdata), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_we(ram_we),
        .eng_done(eng_done), .eng_is_ins(eng_is_ins), .eng_op(eng_op),
        .eng_tag(eng_tag), .eng_word(eng_word)
    );

    load_extend ext0 (
        .clk(clk), .rst(rst),
        .eng_done(eng_done), .eng_is_ins(eng_is_ins), .eng_op(eng_op),
        .eng_tag(eng_tag), .eng_word(eng_word),
        .ins_ready(ins_ready), .ins_value(ins_value),
        .mem_done(mem_done), .done_tag(done_tag), .done_value(done_value),
        .done_is_load(done_is_load)
    );

endmodule

`default_nettype wire

/* hdl/load_extend.sv */
`timescale 1ns/100ps
`default_nettype none

module load_extend
    import mem_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             eng_done,
    input  wire logic             eng_is_ins,
    input  wire logic [op_w-1:0]  eng_op,
    input  wire logic [tag_w-1:0] eng_tag,
    input  wire logic [xlen-1:0]  eng_word,
    output logic                  ins_ready,
    output logic      [xlen-1:0]  ins_value,
    output logic                  mem_done,
    output logic      [tag_w-1:0] done_tag,
    output logic      [xlen-1:0]  done_value,
    output logic                  done_is_load
);

    logic [xlen-1:0] ext_value;
    logic            is_load;

    // Stores fall through to zero
    always_comb begin
        is_load   = 1'b1;
        ext_value = '0;
        case (eng_op)
            op_lb:  ext_value = {{24{eng_word[7]}}, eng_word[7:0]};
            op_lh:  ext_value = {{16{eng_word[15]}}, eng_word[15:0]};
            op_lbu: ext_value = {24'h000000, eng_word[7:0]};
            op_lhu: ext_value = {16'h0000, eng_word[15:0]};
            op_lw:  ext_value = eng_word;
            default: is_load = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ins_ready <= 1'b0;
            mem_done  <= 1'b0;
        end else begin
            ins_ready <= eng_done && eng_is_ins;
            mem_done  <= eng_done && !eng_is_ins;
        end
    end

    always_ff @(posedge clk) begin
        if (eng_done) begin
            ins_value    <= eng_word;
            done_tag     <= eng_tag;
            done_value   <= ext_value;
            done_is_load <= is_load;
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_engine
    import mem_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             fq_valid,
    input  wire logic [xlen-1:0]  fq_addr,
    output logic                  fq_pop,
    input  wire logic             cm_valid,
    input  wire logic [op_w-1:0]  cm_op,
    input  wire logic [xlen-1:0]  cm_addr,
    input  wire logic [xlen-1:0]  cm_data,
    input  wire logic [tag_w-1:0] cm_tag,
    output logic                  cm_take,
    input  wire logic [7:0]       ram_rdata,
    output logic      [xlen-1:0]  ram_addr,
    output logic      [7:0]       ram_wdata,
    output logic                  ram_we,
    output logic                  eng_done,
    output logic                  eng_is_ins,
    output logic      [op_w-1:0]  eng_op,
    output logic      [tag_w-1:0] eng_tag,
    output logic      [xlen-1:0]  eng_word
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } state_t;

    state_t            state;
    logic [bcnt_w-1:0] cnt;
    logic [bcnt_w-1:0] nbytes;
    logic [xlen-1:0]   base;
    logic [xlen-1:0]   job_data;
    logic [bcnt_w-1:0] cm_bytes;
    logic              cm_store;
    logic              accept;
    logic [1:0]        rd_idx;

    // Access size and direction of the committed op
    always_comb begin
        cm_bytes = bytes_w;
        cm_store = 1'b0;
        case (cm_op)
            op_lb, op_lbu: cm_bytes = bytes_b;
            op_lh, op_lhu: cm_bytes = bytes_h;
            op_sb: begin
                cm_bytes = bytes_b;
                cm_store = 1'b1;
            end
            op_sh: begin
                cm_bytes = bytes_h;
                cm_store = 1'b1;
            end
            op_sw: begin
                cm_bytes = bytes_w;
                cm_store = 1'b1;
            end
            default: cm_bytes = bytes_w;
        endcase
    end

    // Committed memory op beats a queued fetch
    assign accept  = (state == st_idle) && (cm_valid || fq_valid);
    assign cm_take = (state == st_idle) && cm_valid;
    assign fq_pop  = (state == st_idle) && !cm_valid && fq_valid;

    // First read address goes out in the accept cycle itself
    assign ram_addr  = (state == st_idle) ? (cm_valid ? cm_addr : fq_addr)
                                          : base + xlen'(cnt);
    assign ram_we    = (state == st_write);
    assign ram_wdata = job_data[{cnt[1:0], 3'b000} +: 8];

    // Byte arriving now was addressed in the previous cycle
    assign rd_idx = cnt[1:0] - 2'd1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= st_idle;
            cnt      <= '0;
            eng_done <= 1'b0;
        end else begin
            eng_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (cm_valid && cm_store) begin
                            state <= st_write;
                            cnt   <= '0;
                        end else begin
                            state <= st_read;
                            cnt   <= 3'd1;
                        end
                    end
                end
                st_read: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == nbytes) begin
                        state    <= st_idle;
                        eng_done <= 1'b1;
                    end
                end
                st_write: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == nbytes - 1'b1) begin
                        state    <= st_idle;
                        eng_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Job payload and read assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            base       <= cm_valid ? cm_addr : fq_addr;
            nbytes     <= cm_valid ? cm_bytes : fetch_bytes;
            job_data   <= cm_data;
            eng_op     <= cm_valid ? cm_op : op_lw;
            eng_tag    <= cm_tag;
            eng_is_ins <= !cm_valid;
            eng_word   <= '0;
        end else if (state == st_read) begin
            eng_word[{rd_idx, 3'b000} +: 8] <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsb_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module lsb_buffer
    import mem_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             issue_valid,
    input  wire logic [tag_w-1:0] issue_tag,
    input  wire logic [op_w-1:0]  issue_op,
    input  wire logic [xlen-1:0]  issue_addr,
    input  wire logic [xlen-1:0]  issue_data,
    input  wire logic             commit_valid,
    input  wire logic [tag_w-1:0] commit_tag,
    input  wire logic             take,
    output logic                  cm_valid,
    output logic      [op_w-1:0]  cm_op,
    output logic      [xlen-1:0]  cm_addr,
    output logic      [xlen-1:0]  cm_data,
    output logic      [tag_w-1:0] cm_tag
);

    logic [op_w-1:0] op_mem   [tag_n];
    logic [xlen-1:0] addr_mem [tag_n];
    logic [xlen-1:0] data_mem [tag_n];
    logic [tag_n-1:0] busy;

    // Entry payload is written at the issue edge
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_mem[issue_tag]   <= issue_op;
            addr_mem[issue_tag] <= issue_addr;
            data_mem[issue_tag] <= issue_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= '0;
            cm_valid <= 1'b0;
            cm_tag   <= '0;
        end else begin
            if (take) begin
                busy[cm_tag] <= 1'b0;
                cm_valid     <= 1'b0;
            end
            if (issue_valid) begin
                busy[issue_tag] <= 1'b1;
            end
            // Commit of an idle entry is ignored
            if (commit_valid && busy[commit_tag]) begin
                cm_valid <= 1'b1;
                cm_tag   <= commit_tag;
            end
        end
    end

    assign cm_op   = op_mem[cm_tag];
    assign cm_addr = addr_mem[cm_tag];
    assign cm_data = data_mem[cm_tag];

endmodule

`default_nettype wire

/* hdl/fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_queue
    import mem_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            push,
    input  wire logic [xlen-1:0] push_addr,
    input  wire logic            pop,
    output logic                 head_valid,
    output logic      [xlen-1:0] head_addr,
    output logic                 full
);

    logic [xlen-1:0] addr_mem [fq_n];
    logic [fq_w-1:0] head;
    logic [fq_w-1:0] tail;
    logic [fq_w:0]   count;
    logic [fq_w:0]   count_nxt;
    logic            push_ok;
    logic            pop_ok;

    // A push into a completely full ring is dropped
    assign push_ok = push && (count != (fq_w + 1)'(fq_n));
    assign pop_ok  = pop && (count != '0);

    always_comb begin
        count_nxt = count;
        if (push_ok && !pop_ok) begin
            count_nxt = count + 1'b1;
        end else if (pop_ok && !push_ok) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            full  <= 1'b0;
        end else begin
            if (push_ok) begin
                tail <= tail + 1'b1;
            end
            if (pop_ok) begin
                head <= head + 1'b1;
            end
            count <= count_nxt;
            // Almost full when at most one free slot is left
            full  <= (count_nxt >= (fq_w + 1)'(fq_n - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            addr_mem[tail] <= push_addr;
        end
    end

    assign head_valid = (count != '0);
    assign head_addr  = addr_mem[head];

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Memory op codes
    localparam int op_w = 5;

    localparam logic [op_w-1:0] op_lb  = 5'b10010;
    localparam logic [op_w-1:0] op_lh  = 5'b10011;
    localparam logic [op_w-1:0] op_lw  = 5'b10100;
    localparam logic [op_w-1:0] op_lbu = 5'b10101;
    localparam logic [op_w-1:0] op_lhu = 5'b10110;
    localparam logic [op_w-1:0] op_sb  = 5'b10111;
    localparam logic [op_w-1:0] op_sh  = 5'b11000;
    localparam logic [op_w-1:0] op_sw  = 5'b11001;

    // Reorder tags and fetch queue sizing
    localparam int tag_w = 3;
    localparam int tag_n = 8;
    localparam int fq_w  = 3;
    localparam int fq_n  = 8;

    localparam int xlen = 32;

    // Byte counts per access size
    localparam int bcnt_w = 3;
    localparam logic [bcnt_w-1:0] bytes_b     = 3'd1;
    localparam logic [bcnt_w-1:0] bytes_h     = 3'd2;
    localparam logic [bcnt_w-1:0] bytes_w     = 3'd4;
    localparam logic [bcnt_w-1:0] fetch_bytes = 3'd4;

endpackage

`default_nettype wire
